// ==== source/stream_pkg.sv ====
package stream_pkg;

    // Width of one word on every stream of the design
    localparam int DATA_WIDTH = 32;

    // One word as it travels on the input and output streams
    typedef logic [DATA_WIDTH-1:0] stream_data_t;

    // Class of the queue a word came from
    // HIGH words are always served before LOW words that are waiting
    typedef enum logic {
        HIGH = 1'b0,
        LOW  = 1'b1
    } prio_t;

endpackage

// ==== source/fifo_pkg.sv ====
package fifo_pkg;

    // Number of words each input queue can hold
    // The pointers rely on this being a power of two so that they wrap by overflow
    localparam int FIFO_DEPTH = 16;

    // Bits needed to index one slot of the buffer
    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

    // The occupancy needs one more bit than the index to hold the full value
    localparam int COUNT_WIDTH = PTR_WIDTH + 1;

    // Read or write index into the circular buffer
    typedef logic [PTR_WIDTH-1:0] fifo_ptr_t;

    // Number of words held, from 0 up to FIFO_DEPTH
    typedef logic [COUNT_WIDTH-1:0] fifo_count_t;

    // State of the output register in the arbiter
    // OUT_EMPTY means the slot can take a word on the next edge
    // OUT_HELD means a word is presented on the output stream
    typedef enum logic {
        OUT_EMPTY = 1'b0,
        OUT_HELD  = 1'b1
    } out_state_t;

endpackage

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo (
    input  logic                    clock,
    input  logic                    rst_n,

    input  stream_pkg::stream_data_t in_data,
    input  logic                    in_valid,
    output logic                    in_ready,

    output stream_pkg::stream_data_t out_data,
    output logic                    out_valid,
    input  logic                    out_ready
);

    import stream_pkg::*;
    import fifo_pkg::*;

    // Storage for the queued words
    stream_data_t mem [FIFO_DEPTH];

    // Next slot to be written by the upstream source
    fifo_ptr_t wr_ptr;

    // Slot holding the oldest word, which is shown on out_data
    fifo_ptr_t rd_ptr;

    // Words currently stored
    fifo_count_t count;

    // Handshake completions on each side in this cycle
    logic do_write;
    logic do_read;

    // Ready and valid come straight from the registered count
    // Neither of them looks at the valid or ready of its own link
    assign in_ready  = (count < fifo_count_t'(FIFO_DEPTH));
    assign out_valid = (count != '0);

    // The oldest word is always visible, even while out_valid is low
    assign out_data = mem[rd_ptr];

    assign do_write = in_valid && in_ready;
    assign do_read  = out_valid && out_ready;

    // The buffer itself is plain storage and keeps its contents over reset
    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers advance on their own handshake and wrap at the buffer end
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy moves by one on a lone write or a lone read
    // A read and a write on the same edge cancel out
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({do_write, do_read})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // The occupancy can never go past the size of the buffer
    a_count_range: assert property (
        @(posedge clock) disable iff (!rst_n)
        count <= fifo_count_t'(FIFO_DEPTH)
    ) else $error("sync_fifo count %0d above depth", count);

    // A full queue that is not being read must not move its write pointer
    // This catches a write slipping in while the queue is full
    a_no_write_when_full: assert property (
        @(posedge clock) disable iff (!rst_n)
        (count == fifo_count_t'(FIFO_DEPTH)) && !do_read |=> $stable(wr_ptr)
    ) else $error("sync_fifo written while full");

    // An empty queue must not move its read pointer on the next edge
    a_no_read_when_empty: assert property (
        @(posedge clock) disable iff (!rst_n)
        (count == '0) |=> $stable(rd_ptr)
    ) else $error("sync_fifo read while empty");

    // The upstream source keeps its word and its valid until the queue takes it
    a_source_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data)
    ) else $error("sync_fifo source dropped or changed a pending word");

endmodule

// ==== source/priority_arbiter.sv ====
`timescale 1ns/1ps

module priority_arbiter (
    input  logic                    clock,
    input  logic                    rst_n,

    input  stream_pkg::stream_data_t hp_data,
    input  logic                    hp_valid,
    output logic                    hp_ready,

    input  stream_pkg::stream_data_t lp_data,
    input  logic                    lp_valid,
    output logic                    lp_ready,

    output stream_pkg::stream_data_t data_out,
    output logic                    data_out_valid,
    input  logic                    data_out_ready
);

    import stream_pkg::*;
    import fifo_pkg::*;

    // Whether the output register currently presents a word
    out_state_t state;

    // Word presented on the output stream
    stream_data_t data_reg;

    // The slot is free when it is empty or its word leaves on this edge
    logic slot_free;

    // A new word enters the register on this edge
    logic load;

    // The high queue wins whenever it has something to offer
    logic take_hp;

    assign slot_free = (state == OUT_EMPTY) || data_out_ready;
    assign load      = slot_free && (hp_valid || lp_valid);
    assign take_hp   = hp_valid;

    // Exactly the chosen queue is popped when the register loads
    // Under back-pressure slot_free is low so both queues stay untouched
    assign hp_ready = load && take_hp;
    assign lp_ready = load && !take_hp && lp_valid;

    assign data_out       = data_reg;
    assign data_out_valid = (state == OUT_HELD);

    // Control state of the output slot
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= OUT_EMPTY;
        end else if (load) begin
            state <= OUT_HELD;
        end else if (state == OUT_HELD && data_out_ready) begin
            // Word accepted downstream and nothing waiting behind it
            state <= OUT_EMPTY;
        end
    end

    // Payload follows the load decision and needs no reset
    always_ff @(posedge clock) begin
        if (load) begin
            data_reg <= take_hp ? hp_data : lp_data;
        end
    end

    // A presented word stays on the bus until the sink takes it
    a_out_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out)
    ) else $error("priority_arbiter changed data_out under back-pressure");

    // Only one queue is popped on any edge
    a_one_pop: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(hp_ready && lp_ready)
    ) else $error("priority_arbiter popped both queues");

    // The low queue is never served while the high queue offers a word
    a_lp_blocked: assert property (
        @(posedge clock) disable iff (!rst_n)
        lp_ready |-> !hp_valid
    ) else $error("priority_arbiter served low queue over a waiting high word");

endmodule

// ==== source/prioritised_fifo.sv ====
`timescale 1ns/1ps

module prioritised_fifo (
    input  logic                    clock,
    input  logic                    rst_n,

    // High-priority input stream
    input  stream_pkg::stream_data_t data_in_hp,
    input  logic                    data_in_hp_valid,
    output logic                    data_in_hp_ready,

    // Low-priority input stream
    input  stream_pkg::stream_data_t data_in_lp,
    input  logic                    data_in_lp_valid,
    output logic                    data_in_lp_ready,

    // Merged output stream
    output stream_pkg::stream_data_t data_out,
    output logic                    data_out_valid,
    input  logic                    data_out_ready
);

    import stream_pkg::*;

    // Head of the high-priority queue towards the arbiter
    stream_data_t hp_q_data;
    logic         hp_q_valid;
    logic         hp_q_ready;

    // Head of the low-priority queue towards the arbiter
    stream_data_t lp_q_data;
    logic         lp_q_valid;
    logic         lp_q_ready;

    // Each class gets its own queue so that it keeps its arrival order
    sync_fifo hp_queue (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_data   (data_in_hp),
        .in_valid  (data_in_hp_valid),
        .in_ready  (data_in_hp_ready),
        .out_data  (hp_q_data),
        .out_valid (hp_q_valid),
        .out_ready (hp_q_ready)
    );

    sync_fifo lp_queue (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_data   (data_in_lp),
        .in_valid  (data_in_lp_valid),
        .in_ready  (data_in_lp_ready),
        .out_data  (lp_q_data),
        .out_valid (lp_q_valid),
        .out_ready (lp_q_ready)
    );

    // The output stage drains the high queue first and adds one cycle of latency
    priority_arbiter arbiter (
        .clock          (clock),
        .rst_n          (rst_n),
        .hp_data        (hp_q_data),
        .hp_valid       (hp_q_valid),
        .hp_ready       (hp_q_ready),
        .lp_data        (lp_q_data),
        .lp_valid       (lp_q_valid),
        .lp_ready       (lp_q_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

endmodule

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS = 100
) (
    input  logic restart,
    output logic clock,
    output logic rst_n
);

    // High once the first of the two reset cycles has gone by
    logic first_done;

    initial begin
        clock      = 1'b0;
        rst_n      = 1'b0;
        first_done = 1'b0;
    end

    always #(PERIOD_NS / 2) clock = ~clock;

    // Reset stays low over two rising edges, at power-up and after each restart request
    always @(posedge clock) begin
        if (restart) begin
            rst_n      <= 1'b0;
            first_done <= 1'b0;
        end else if (!first_done) begin
            first_done <= 1'b1;
        end else begin
            rst_n <= 1'b1;
        end
    end

endmodule

// ==== tb/fifo_checker.sv ====
`timescale 1ns/1ps

module fifo_checker (
    input  logic                     clock,
    input  logic                     rst_n,
    input  stream_pkg::stream_data_t data_in_hp,
    input  logic                     data_in_hp_valid,
    input  logic                     data_in_hp_ready,
    input  stream_pkg::stream_data_t data_in_lp,
    input  logic                     data_in_lp_valid,
    input  logic                     data_in_lp_ready,
    input  stream_pkg::stream_data_t data_out,
    input  logic                     data_out_valid,
    input  logic                     data_out_ready,
    output int                       mismatch_count,
    output int                       error_count,
    output int                       words_out
);

    import stream_pkg::*;
    import fifo_pkg::*;

    // Words still inside each queue, oldest first, with the edge that accepted each one
    stream_data_t hp_words[$];
    stream_data_t lp_words[$];
    int           hp_edges[$];
    int           lp_edges[$];

    // Number of the rising edge that follows the current sample
    int tick;

    // Predicted occupancy of each queue
    fifo_count_t hp_count;
    fifo_count_t lp_count;

    // Output stream as it looked at the previous sample
    logic         prev_valid;
    logic         prev_ready;
    stream_data_t prev_data;

    // Set during reset, cleared by the first sample with rst_n high
    logic after_reset;

    initial begin
        mismatch_count = 0;
        error_count    = 0;
        words_out      = 0;
        tick           = 0;
        prev_valid     = 1'b0;
        prev_ready     = 1'b0;
        prev_data      = '0;
        after_reset    = 1'b0;
    end

    task automatic report_mismatch(input string name, input stream_data_t expected,
                                   input stream_data_t actual);
        $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                 $time, name, expected, actual);
        mismatch_count++;
    endtask

    task automatic report_error(input string what);
        $display("ERROR time=%0t %s", $time, what);
        error_count++;
    endtask

    // True when some queue held a word that was already readable at the given edge
    function automatic logic word_waiting(input int load_edge);
        return (hp_words.size() > 0 && hp_edges[0] < load_edge) ||
               (lp_words.size() > 0 && lp_edges[0] < load_edge);
    endfunction

    // A word entered the output register at load_edge
    // A high word that was readable by then has to be the one chosen
    task automatic take_loaded_word(input int load_edge);
        stream_data_t expected;
        prio_t        cls;
        logic         found;
        int           dropped;
        found = 1'b1;
        if (hp_words.size() > 0 && hp_edges[0] < load_edge) begin
            expected = hp_words.pop_front();
            dropped  = hp_edges.pop_front();
            cls      = HIGH;
        end else if (lp_words.size() > 0 && lp_edges[0] < load_edge) begin
            expected = lp_words.pop_front();
            dropped  = lp_edges.pop_front();
            cls      = LOW;
        end else begin
            found = 1'b0;
        end
        if (!found) begin
            report_error("output register loaded while no word was waiting");
        end else if (data_out !== expected) begin
            if (cls == HIGH && lp_words.size() > 0 && data_out === lp_words[0]) begin
                report_error("low-priority word loaded while a high-priority word waited");
            end else begin
                report_mismatch($sformatf("data_out(%s)", cls.name()), expected, data_out);
            end
        end
    endtask

    // Called at the end of the run, after the output has been drained
    task automatic check_empty();
        if (hp_words.size() != 0 || lp_words.size() != 0) begin
            report_error($sformatf("%0d high and %0d low words never left the FIFO",
                                   hp_words.size(), lp_words.size()));
        end
    endtask

    // Sampling at the falling edge sees the values that the next rising edge acts on
    always @(negedge clock) begin
        tick = tick + 1;
        if (!rst_n) begin
            // Reset throws away everything the queues and the register held
            hp_words.delete();
            lp_words.delete();
            hp_edges.delete();
            lp_edges.delete();
            prev_valid  = 1'b0;
            prev_ready  = 1'b0;
            after_reset = 1'b1;
        end else begin
            if (after_reset && data_out_valid) begin
                report_error("data_out_valid is high right after reset");
            end
            after_reset = 1'b0;

            // The register was free on the last edge, so a waiting word must have moved in
            if (!prev_valid || prev_ready) begin
                if (data_out_valid) begin
                    take_loaded_word(tick - 1);
                end else if (word_waiting(tick - 1)) begin
                    report_error("output register stayed empty while a word was waiting");
                end
            end else if (!data_out_valid) begin
                report_error("data_out_valid dropped before the word was accepted");
            end else if (data_out !== prev_data) begin
                report_mismatch("data_out", prev_data, data_out);
            end

            // Ready follows the occupancy only
            hp_count = fifo_count_t'(hp_words.size());
            lp_count = fifo_count_t'(lp_words.size());
            if (data_in_hp_ready !== (hp_count < fifo_count_t'(FIFO_DEPTH))) begin
                report_mismatch("data_in_hp_ready", hp_count < fifo_count_t'(FIFO_DEPTH),
                                data_in_hp_ready);
            end
            if (data_in_lp_ready !== (lp_count < fifo_count_t'(FIFO_DEPTH))) begin
                report_mismatch("data_in_lp_ready", lp_count < fifo_count_t'(FIFO_DEPTH),
                                data_in_lp_ready);
            end

            // Transfers that complete on the coming edge
            if (data_in_hp_valid && data_in_hp_ready) begin
                hp_words.push_back(data_in_hp);
                hp_edges.push_back(tick);
            end
            if (data_in_lp_valid && data_in_lp_ready) begin
                lp_words.push_back(data_in_lp);
                lp_edges.push_back(tick);
            end
            if (data_out_valid && data_out_ready) begin
                words_out++;
            end
            prev_valid = data_out_valid;
            prev_ready = data_out_ready;
            prev_data  = data_out;
        end
    end

endmodule

// ==== tb/prioritised_fifo_tb.sv ====
`timescale 1ns/1ps

module prioritised_fifo_tb;

    import stream_pkg::*;

    localparam int CLOCK_PERIOD_NS = 100;

    // Length of each part of the run in clock cycles
    localparam int FILL_CYCLES      = 40;
    localparam int RANDOM_CYCLES    = 400;
    localparam int RESET_CYCLES     = 8;
    localparam int LOW_FIRST_CYCLES = 10;
    localparam int MIXED_CYCLES     = 150;
    localparam int DRAIN_CYCLES     = 40;
    localparam int STIM_CYCLES      = FILL_CYCLES + RANDOM_CYCLES + 2 * RESET_CYCLES
                                      + LOW_FIRST_CYCLES + MIXED_CYCLES + DRAIN_CYCLES;

    logic         clock;
    logic         rst_n;
    logic         restart;
    stream_data_t data_in_hp;
    logic         data_in_hp_valid;
    logic         data_in_hp_ready;
    stream_data_t data_in_lp;
    logic         data_in_lp_valid;
    logic         data_in_lp_ready;
    stream_data_t data_out;
    logic         data_out_valid;
    logic         data_out_ready;

    int     mismatch_count;
    int     error_count;
    int     words_out;
    int     timed_out;
    int     idle_streak;
    integer seed;

    clock_gen #(.PERIOD_NS(CLOCK_PERIOD_NS)) clock_source (
        .restart (restart),
        .clock   (clock),
        .rst_n   (rst_n)
    );

    prioritised_fifo uut (
        .clock            (clock),
        .rst_n            (rst_n),
        .data_in_hp       (data_in_hp),
        .data_in_hp_valid (data_in_hp_valid),
        .data_in_hp_ready (data_in_hp_ready),
        .data_in_lp       (data_in_lp),
        .data_in_lp_valid (data_in_lp_valid),
        .data_in_lp_ready (data_in_lp_ready),
        .data_out         (data_out),
        .data_out_valid   (data_out_valid),
        .data_out_ready   (data_out_ready)
    );

    fifo_checker fifo_check (
        .clock            (clock),
        .rst_n            (rst_n),
        .data_in_hp       (data_in_hp),
        .data_in_hp_valid (data_in_hp_valid),
        .data_in_hp_ready (data_in_hp_ready),
        .data_in_lp       (data_in_lp),
        .data_in_lp_valid (data_in_lp_valid),
        .data_in_lp_ready (data_in_lp_ready),
        .data_out         (data_out),
        .data_out_valid   (data_out_valid),
        .data_out_ready   (data_out_ready),
        .mismatch_count   (mismatch_count),
        .error_count      (error_count),
        .words_out        (words_out)
    );

    // High with the given chance in percent
    function automatic logic roll(input int percent);
        int draw;
        draw = $unsigned($random(seed)) % 100;
        return draw < percent;
    endfunction

    // One clock cycle of stimulus
    // A pending word keeps its valid and data until the edge that takes it
    task automatic step(input int hp_pct, input int lp_pct, input int ready_pct);
        logic hp_free;
        logic lp_free;
        @(negedge clock);
        hp_free = !data_in_hp_valid || data_in_hp_ready;
        lp_free = !data_in_lp_valid || data_in_lp_ready;
        if (!data_in_hp_valid && !data_in_lp_valid && !data_out_valid) begin
            idle_streak++;
        end else begin
            idle_streak = 0;
        end
        @(posedge clock);
        if (hp_free) begin
            data_in_hp_valid <= roll(hp_pct);
            data_in_hp       <= $random(seed);
        end
        if (lp_free) begin
            data_in_lp_valid <= roll(lp_pct);
            data_in_lp       <= $random(seed);
        end
        data_out_ready <= roll(ready_pct);
    endtask

    task automatic wait_reset_release();
        do begin
            @(negedge clock);
        end while (!rst_n);
    endtask

    // Pulls reset in the middle of traffic
    // Pending words stay valid up to the edge that takes rst_n low and are dropped there
    task automatic apply_reset();
        @(posedge clock);
        restart <= 1'b1;
        @(posedge clock);
        restart          <= 1'b0;
        data_in_hp_valid <= 1'b0;
        data_in_lp_valid <= 1'b0;
        data_out_ready   <= 1'b0;
        wait_reset_release();
    endtask

    // Two idle samples in a row mean both queues and the register are empty
    task automatic drain_output();
        idle_streak = 0;
        while (idle_streak < 2) begin
            step(0, 0, 100);
        end
    endtask

    task automatic print_summary();
        $display("Summary: %0d words out, %0d mismatches, %0d other errors, %0d timeouts",
                 words_out, mismatch_count, error_count, timed_out);
    endtask

    initial begin
        seed             = 32'hb9096b75;
        restart          = 1'b0;
        data_in_hp       = '0;
        data_in_hp_valid = 1'b0;
        data_in_lp       = '0;
        data_in_lp_valid = 1'b0;
        data_out_ready   = 1'b0;
        idle_streak      = 0;
        timed_out        = 0;

        wait_reset_release();

        // Both queues fill up behind a stalled output
        repeat (FILL_CYCLES) step(100, 100, 0);
        repeat (RANDOM_CYCLES) step(60, 40, 70);

        // After a reset the low input starts first, so its first word leaves first
        apply_reset();
        repeat (LOW_FIRST_CYCLES) step(0, 100, 30);
        repeat (MIXED_CYCLES) step(70, 50, 60);

        drain_output();
        fifo_check.check_empty();
        print_summary();
        if (mismatch_count == 0 && error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Stops a run that hangs, for instance when the output never drains
    initial begin
        #((STIM_CYCLES + 100) * CLOCK_PERIOD_NS);
        timed_out = 1;
        $display("ERROR time=%0t timeout, the run did not end within %0d cycles",
                 $time, STIM_CYCLES + 100);
        print_summary();
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== list.f ====
source/stream_pkg.sv
source/fifo_pkg.sv
source/sync_fifo.sv
source/priority_arbiter.sv
source/prioritised_fifo.sv
tb/clock_gen.sv
tb/fifo_checker.sv
tb/prioritised_fifo_tb.sv
